/* all.f */
src/tap_pkg.sv
src/graph_pkg.sv
src/tap_decoder.sv
src/input_decoder.sv
src/node_id_mapper.sv
src/root_counter.sv
src/tap_encoder.sv
src/user_logic.sv
verification/tb_clock.sv
verification/result_checker.sv
verification/user_logic_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f all.f --top-module user_logic_tb -o user_logic_tb

out=$(./obj_dir/user_logic_tb)
echo "$out"

# The run passes only if the pass message was printed
echo "$out" | grep -q "TB PASSED"

/* src/graph_pkg.sv */
`default_nettype none

package graph_pkg;

    // Device names are three lower-case letters
    localparam int NAME_CHARS = 3;
    localparam int BIN_BITS = 5;
    localparam int NAME_BITS = NAME_CHARS * BIN_BITS;
    localparam int CHAR_CNT_BITS = $clog2(NAME_CHARS + 1);

    // Name table size and index widths
    localparam int MAX_NODES = 16;
    localparam int NODE_BITS = $clog2(MAX_NODES);
    localparam int COUNT_BITS = $clog2(MAX_NODES + 1);

    // First letter in the high bits
    typedef logic [NAME_BITS-1:0] device_t;
    typedef logic [CHAR_CNT_BITS-1:0] char_cnt_t;
    typedef logic [NODE_BITS-1:0] node_t;
    typedef logic [COUNT_BITS-1:0] count_t;

endpackage

`default_nettype wire

/* src/input_decoder.sv */
`default_nettype none

module input_decoder (
    input  logic               tck,
    input  logic               arst_n,
    input  logic               test_logic_reset,
    input  logic               byte_valid,
    input  tap_pkg::byte_t     byte_data,
    output logic               src_valid,
    output logic               edge_valid,
    output logic               decoding_done,
    output graph_pkg::device_t src_name,
    output graph_pkg::device_t dst_name
);

    typedef enum logic [1:0] {
        idle_line,
        in_source,
        after_colon,
        in_dest
    } state_t;

    state_t                         state;
    graph_pkg::device_t             name_q;
    graph_pkg::char_cnt_t           char_cnt;
    tap_pkg::byte_t                 letter_ofs;
    logic [graph_pkg::BIN_BITS-1:0] letter_code;
    logic                           is_letter;
    logic                           is_colon;
    logic                           is_space;
    logic                           is_newline;
    logic                           is_eot;
    logic                           name_full;

    // Character classes
    assign is_letter   = (byte_data >= "a") && (byte_data <= "z");
    assign is_colon    = (byte_data == ":");
    assign is_space    = (byte_data == " ");
    assign is_newline  = (byte_data == "\n");
    assign is_eot      = (byte_data == tap_pkg::EOT_CHAR);
    assign letter_ofs  = byte_data - "a";
    assign letter_code = letter_ofs[graph_pkg::BIN_BITS-1:0];
    assign name_full   = (char_cnt == graph_pkg::char_cnt_t'(graph_pkg::NAME_CHARS));

    // Letters shift in from the bottom, older ones move up
    always_ff @(posedge tck) begin
        if (byte_valid && is_letter) begin
            name_q <= {name_q[graph_pkg::NAME_BITS-graph_pkg::BIN_BITS-1:0], letter_code};
        end
        if (byte_valid && is_colon) begin
            src_name <= name_q;
        end
        if (byte_valid && (is_space || is_newline)) begin
            dst_name <= name_q;
        end
    end

    always_ff @(posedge tck or negedge arst_n) begin
        if (!arst_n) begin
            state         <= idle_line;
            char_cnt      <= '0;
            src_valid     <= 1'b0;
            edge_valid    <= 1'b0;
            decoding_done <= 1'b0;
        end else if (test_logic_reset) begin
            state         <= idle_line;
            char_cnt      <= '0;
            src_valid     <= 1'b0;
            edge_valid    <= 1'b0;
            decoding_done <= 1'b0;
        end else begin
            src_valid     <= 1'b0;
            edge_valid    <= 1'b0;
            decoding_done <= 1'b0;
            if (byte_valid && is_eot) begin
                decoding_done <= 1'b1;
                state         <= idle_line;
                char_cnt      <= '0;
            end else if (byte_valid) begin
                case (state)
                    idle_line: begin
                        if (is_letter) begin
                            char_cnt <= graph_pkg::char_cnt_t'(1);
                            state    <= in_source;
                        end
                    end
                    in_source: begin
                        if (is_letter && !name_full) begin
                            char_cnt <= char_cnt + 1'b1;
                        end else if (is_colon) begin
                            src_valid <= name_full;
                            state     <= after_colon;
                        end else if (is_newline) begin
                            state <= idle_line;
                        end
                    end
                    after_colon: begin
                        if (is_letter) begin
                            char_cnt <= graph_pkg::char_cnt_t'(1);
                            state    <= in_dest;
                        end else if (is_newline) begin
                            state <= idle_line;
                        end
                    end
                    in_dest: begin
                        if (is_letter && !name_full) begin
                            char_cnt <= char_cnt + 1'b1;
                        end else if (is_space || is_newline) begin
                            // Short names are dropped silently
                            edge_valid <= name_full;
                            state      <= is_newline ? idle_line : after_colon;
                        end
                    end
                    default: state <= idle_line;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* src/node_id_mapper.sv */
`default_nettype none

module node_id_mapper (
    input  logic               tck,
    input  logic               arst_n,
    input  logic               test_logic_reset,
    input  logic               src_valid,
    input  logic               edge_valid,
    input  logic               decoding_done,
    input  graph_pkg::device_t src_name,
    input  graph_pkg::device_t dst_name,
    output logic               edge_idx_valid,
    output logic               done_idx,
    output graph_pkg::node_t   dst_idx,
    output graph_pkg::count_t  node_cnt
);

    graph_pkg::device_t names [graph_pkg::MAX_NODES];
    graph_pkg::device_t lookup_name;
    graph_pkg::node_t   hit_idx;
    logic               hit;
    logic               full;
    logic               lookup;

    assign lookup      = src_valid || edge_valid;
    assign lookup_name = edge_valid ? dst_name : src_name;
    assign full        = (node_cnt == graph_pkg::count_t'(graph_pkg::MAX_NODES));

    // Parallel compare against every allocated entry
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < graph_pkg::MAX_NODES; i++) begin
            if ((graph_pkg::count_t'(i) < node_cnt) && (names[i] == lookup_name)) begin
                hit     = 1'b1;
                hit_idx = graph_pkg::node_t'(i);
            end
        end
    end

    // New names go to the next free slot
    always_ff @(posedge tck) begin
        if (lookup && !hit && !full) begin
            names[node_cnt[graph_pkg::NODE_BITS-1:0]] <= lookup_name;
        end
        if (edge_valid) begin
            dst_idx <= hit ? hit_idx : node_cnt[graph_pkg::NODE_BITS-1:0];
        end
    end

    always_ff @(posedge tck or negedge arst_n) begin
        if (!arst_n) begin
            node_cnt       <= '0;
            edge_idx_valid <= 1'b0;
            done_idx       <= 1'b0;
        end else if (test_logic_reset) begin
            node_cnt       <= '0;
            edge_idx_valid <= 1'b0;
            done_idx       <= 1'b0;
        end else begin
            edge_idx_valid <= edge_valid && (hit || !full);
            done_idx       <= decoding_done;
            // Count stays visible during done_idx, then the table empties
            if (done_idx) begin
                node_cnt <= '0;
            end else if (lookup && !hit && !full) begin
                node_cnt <= node_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/root_counter.sv */
`default_nettype none

module root_counter (
    input  logic              tck,
    input  logic              arst_n,
    input  logic              test_logic_reset,
    input  logic              edge_idx_valid,
    input  logic              done_idx,
    input  graph_pkg::node_t  dst_idx,
    input  graph_pkg::count_t node_cnt,
    output logic              result_valid,
    output tap_pkg::result_t  result
);

    logic [graph_pkg::MAX_NODES-1:0] has_incoming;
    graph_pkg::count_t               root_cnt;

    // Allocated nodes that no edge points to
    always_comb begin
        root_cnt = '0;
        for (int i = 0; i < graph_pkg::MAX_NODES; i++) begin
            if ((graph_pkg::count_t'(i) < node_cnt) && !has_incoming[i]) begin
                root_cnt = root_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge tck) begin
        if (done_idx) begin
            result <= tap_pkg::result_t'(root_cnt);
        end
    end

    always_ff @(posedge tck or negedge arst_n) begin
        if (!arst_n) begin
            has_incoming <= '0;
            result_valid <= 1'b0;
        end else if (test_logic_reset) begin
            has_incoming <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= done_idx;
            if (done_idx) begin
                has_incoming <= '0;
            end else if (edge_idx_valid) begin
                has_incoming[dst_idx] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/tap_decoder.sv */
`default_nettype none

module tap_decoder (
    input  logic           tck,
    input  logic           arst_n,
    input  logic           tdi,
    input  logic           test_logic_reset,
    input  logic           ir_is_user,
    input  logic           shift_dr,
    input  logic           update_dr,
    output logic           byte_valid,
    output tap_pkg::byte_t byte_data
);

    tap_pkg::byte_t shift_q;

    // LSB first, so the first bit ends up in bit 0 after 8 shifts
    always_ff @(posedge tck) begin
        if (ir_is_user && shift_dr) begin
            shift_q <= {tdi, shift_q[tap_pkg::BYTE_BITS-1:1]};
        end
        if (ir_is_user && update_dr) begin
            byte_data <= shift_q;
        end
    end

    // One strobe per user DR update
    always_ff @(posedge tck or negedge arst_n) begin
        if (!arst_n) begin
            byte_valid <= 1'b0;
        end else if (test_logic_reset) begin
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= ir_is_user && update_dr;
        end
    end

endmodule

`default_nettype wire

/* src/tap_encoder.sv */
`default_nettype none

module tap_encoder (
    input  logic             tck,
    input  logic             arst_n,
    input  logic             test_logic_reset,
    input  logic             ir_is_user,
    input  logic             capture_dr,
    input  logic             shift_dr,
    input  logic             result_valid,
    input  tap_pkg::result_t result,
    output logic             tdo
);

    tap_pkg::result_t held_q;
    tap_pkg::result_t shift_q;

    // Bit 0 leaves first
    assign tdo = shift_q[0];

    always_ff @(posedge tck or negedge arst_n) begin
        if (!arst_n) begin
            held_q  <= '0;
            shift_q <= '0;
        end else if (test_logic_reset) begin
            held_q  <= '0;
            shift_q <= '0;
        end else begin
            if (result_valid) begin
                held_q <= result;
            end
            if (ir_is_user && capture_dr) begin
                shift_q <= held_q;
            end else if (ir_is_user && shift_dr) begin
                shift_q <= {1'b0, shift_q[tap_pkg::RESULT_BITS-1:1]};
            end
        end
    end

endmodule

`default_nettype wire

/* src/tap_pkg.sv */
`default_nettype none

package tap_pkg;

    // One character per DR scan
    localparam int BYTE_BITS = 8;

    // Answer scanned back out on tdo
    localparam int RESULT_BITS = 16;

    typedef logic [BYTE_BITS-1:0] byte_t;
    typedef logic [RESULT_BITS-1:0] result_t;

    // End of transmission closes a graph
    localparam byte_t EOT_CHAR = 8'h04;

endpackage

`default_nettype wire

/* src/user_logic.sv */
`default_nettype none

module user_logic (
    input  logic tck,
    input  logic arst_n,
    input  logic tdi,
    input  logic test_logic_reset,
    input  logic run_test_idle,
    input  logic ir_is_user,
    input  logic capture_dr,
    input  logic shift_dr,
    input  logic update_dr,
    output logic tdo
);

    logic               byte_valid;
    tap_pkg::byte_t     byte_data;
    logic               src_valid;
    logic               edge_valid;
    logic               decoding_done;
    graph_pkg::device_t src_name;
    graph_pkg::device_t dst_name;
    logic               edge_idx_valid;
    logic               done_idx;
    graph_pkg::node_t   dst_idx;
    graph_pkg::count_t  node_cnt;
    logic               result_valid;
    tap_pkg::result_t   result;

    // Scan bits to bytes
    tap_decoder tap_decoder_i (
        .tck              (tck),
        .arst_n           (arst_n),
        .tdi              (tdi),
        .test_logic_reset (test_logic_reset),
        .ir_is_user       (ir_is_user),
        .shift_dr         (shift_dr),
        .update_dr        (update_dr),
        .byte_valid       (byte_valid),
        .byte_data        (byte_data)
    );

    // Bytes to named sources and edges
    input_decoder input_decoder_i (
        .tck              (tck),
        .arst_n           (arst_n),
        .test_logic_reset (test_logic_reset),
        .byte_valid       (byte_valid),
        .byte_data        (byte_data),
        .src_valid        (src_valid),
        .edge_valid       (edge_valid),
        .decoding_done    (decoding_done),
        .src_name         (src_name),
        .dst_name         (dst_name)
    );

    node_id_mapper node_id_mapper_i (
        .tck              (tck),
        .arst_n           (arst_n),
        .test_logic_reset (test_logic_reset),
        .src_valid        (src_valid),
        .edge_valid       (edge_valid),
        .decoding_done    (decoding_done),
        .src_name         (src_name),
        .dst_name         (dst_name),
        .edge_idx_valid   (edge_idx_valid),
        .done_idx         (done_idx),
        .dst_idx          (dst_idx),
        .node_cnt         (node_cnt)
    );

    root_counter root_counter_i (
        .tck              (tck),
        .arst_n           (arst_n),
        .test_logic_reset (test_logic_reset),
        .edge_idx_valid   (edge_idx_valid),
        .done_idx         (done_idx),
        .dst_idx          (dst_idx),
        .node_cnt         (node_cnt),
        .result_valid     (result_valid),
        .result           (result)
    );

    // Root count back out on tdo, run_test_idle is not needed here
    tap_encoder tap_encoder_i (
        .tck              (tck),
        .arst_n           (arst_n),
        .test_logic_reset (test_logic_reset),
        .ir_is_user       (ir_is_user),
        .capture_dr       (capture_dr),
        .shift_dr         (shift_dr),
        .result_valid     (result_valid),
        .result           (result),
        .tdo              (tdo)
    );

endmodule

`default_nettype wire

/* verification/result_checker.sv */
`default_nettype none

module result_checker (
    input  logic             tck,
    input  logic             tdo,
    input  logic             ir_is_user,
    input  logic             capture_dr,
    input  logic             shift_dr,
    input  logic             check_start,
    input  tap_pkg::result_t exp_value,
    input  logic [127:0]     test_name,
    output int               checks_done,
    output int               errors
);

    tap_pkg::result_t shifted = '0;
    tap_pkg::result_t want = '0;
    logic [127:0]     name_q = '0;
    logic             armed = 1'b0;
    int               bit_cnt = 0;
    int               done_cnt = 0;
    int               err_cnt = 0;

    assign checks_done = done_cnt;
    assign errors      = err_cnt;

    // Inputs change on the falling edge, so the rising edge sees them settled
    always @(posedge tck) begin
        if (check_start && capture_dr && ir_is_user) begin
            // Readout begins with the user capture
            armed   = 1'b1;
            bit_cnt = 0;
            shifted = '0;
            want    = exp_value;
            name_q  = test_name;
        end else if (armed && ir_is_user && shift_dr) begin
            // Bit 0 comes out first
            shifted = {tdo, shifted[tap_pkg::RESULT_BITS-1:1]};
            bit_cnt = bit_cnt + 1;
            if (bit_cnt == tap_pkg::RESULT_BITS) begin
                armed    = 1'b0;
                done_cnt = done_cnt + 1;
                if (shifted !== want) begin
                    $display("** Error: test %0d %s: expected 0x%04h, actual 0x%04h",
                             done_cnt, name_q, want, shifted);
                    err_cnt = err_cnt + 1;
                end else begin
                    $display("Test %0d %s: ok, 0x%04h", done_cnt, name_q, shifted);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
`default_nettype none

module tb_clock (
    output logic tck
);

    localparam int HALF_PERIOD = 50;

    initial begin
        tck = 1'b0;
    end

    // Period of 100
    always #HALF_PERIOD tck = ~tck;

endmodule

`default_nettype wire

/* verification/user_logic_tb.sv */
`default_nettype none

module user_logic_tb;

    localparam int RESET_CYCLES = 5;
    localparam int SETTLE_CYCLES = 6;
    localparam int NUM_RANDOM = 20;
    localparam int NUM_READOUTS = NUM_RANDOM + 7;
    localparam logic [31:0] SEED = 32'h21d9abfd;
    localparam int NAME_W = 8 * graph_pkg::NAME_CHARS;

    // Worst case: 6 lines of a source and 3 destinations, plus EOT
    localparam int SCAN_CYCLES = 10;
    localparam int LINE_BYTES = 4 * (graph_pkg::NAME_CHARS + 1) + 1;
    localparam int GRAPH_CYCLES = (6 * LINE_BYTES + 1) * SCAN_CYCLES + SETTLE_CYCLES;
    localparam int GRAPH_EQUIV = NUM_RANDOM + 6;
    localparam int READOUT_CYCLES = 18;
    localparam int WORST_CYCLES = GRAPH_EQUIV * GRAPH_CYCLES
                                + NUM_READOUTS * READOUT_CYCLES + RESET_CYCLES + 10;
    localparam int TIMEOUT_CYCLES = WORST_CYCLES * 3 / 2;

    logic             tck;
    logic             arst_n;
    logic             tdi;
    logic             test_logic_reset;
    logic             run_test_idle;
    logic             ir_is_user;
    logic             capture_dr;
    logic             shift_dr;
    logic             update_dr;
    logic             tdo;
    logic             check_start;
    tap_pkg::result_t exp_value;
    logic [127:0]     test_name;
    int               checks_done;
    int               errors;
    int               cycle_cnt = 0;

    // Stimulus and reference model state
    logic [31:0]      lfsr;
    logic [NAME_W-1:0] pool [graph_pkg::MAX_NODES];
    tap_pkg::byte_t   text_q [$];
    bit               seen [logic [NAME_W-1:0]];
    bit               targeted [logic [NAME_W-1:0]];
    tap_pkg::result_t model_result;

    tb_clock clock_i (
        .tck (tck)
    );

    user_logic DUT (
        .tck              (tck),
        .arst_n           (arst_n),
        .tdi              (tdi),
        .test_logic_reset (test_logic_reset),
        .run_test_idle    (run_test_idle),
        .ir_is_user       (ir_is_user),
        .capture_dr       (capture_dr),
        .shift_dr         (shift_dr),
        .update_dr        (update_dr),
        .tdo              (tdo)
    );

    result_checker check_i (
        .tck         (tck),
        .tdo         (tdo),
        .ir_is_user  (ir_is_user),
        .capture_dr  (capture_dr),
        .shift_dr    (shift_dr),
        .check_start (check_start),
        .exp_value   (exp_value),
        .test_name   (test_name),
        .checks_done (checks_done),
        .errors      (errors)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    // Sixteen distinct three-letter names
    task automatic fill_pool();
        int              v;
        logic [NAME_W-1:0] nm;
        bit              dup;
        for (int k = 0; k < graph_pkg::MAX_NODES; k++) begin
            do begin
                nm = '0;
                for (int c = 0; c < graph_pkg::NAME_CHARS; c++) begin
                    draw_bits(graph_pkg::BIN_BITS, v);
                    nm = {nm[NAME_W-9:0], 8'(97 + v % 26)};
                end
                dup = 1'b0;
                for (int j = 0; j < k; j++) begin
                    if (pool[j] == nm) begin
                        dup = 1'b1;
                    end
                end
            end while (dup);
            pool[k] = nm;
        end
    endtask

    task automatic push_name(input logic [NAME_W-1:0] nm);
        for (int c = graph_pkg::NAME_CHARS - 1; c >= 0; c--) begin
            text_q.push_back(nm[8*c +: 8]);
        end
    endtask

    // Random graph text and its root count
    task automatic make_graph();
        int lines;
        int dests;
        int v;
        int src;
        int dst;
        text_q.delete();
        seen.delete();
        targeted.delete();
        draw_bits(3, v);
        lines = 1 + v % 6;
        for (int l = 0; l < lines; l++) begin
            draw_bits(graph_pkg::NODE_BITS, src);
            push_name(pool[src]);
            text_q.push_back(":");
            seen[pool[src]] = 1'b1;
            draw_bits(2, v);
            dests = 1 + v % 3;
            for (int d = 0; d < dests; d++) begin
                draw_bits(graph_pkg::NODE_BITS, dst);
                text_q.push_back(" ");
                push_name(pool[dst]);
                seen[pool[dst]]     = 1'b1;
                targeted[pool[dst]] = 1'b1;
            end
            text_q.push_back("\n");
        end
        text_q.push_back(tap_pkg::EOT_CHAR);
        model_result = tap_pkg::result_t'(seen.num() - targeted.num());
    endtask

    // Only aaa has no incoming edge
    task automatic load_fixed();
        string txt;
        txt = "aaa: bbb ccc\nbbb: ccc\n";
        text_q.delete();
        for (int i = 0; i < txt.len(); i++) begin
            text_q.push_back(txt[i]);
        end
        text_q.push_back(tap_pkg::EOT_CHAR);
        model_result = tap_pkg::result_t'(1);
    endtask

    task automatic scan_byte(input tap_pkg::byte_t b, input logic user);
        for (int i = 0; i < tap_pkg::BYTE_BITS; i++) begin
            @(negedge tck);
            ir_is_user = user;
            shift_dr   = 1'b1;
            tdi        = b[i];
        end
        @(negedge tck);
        shift_dr  = 1'b0;
        update_dr = 1'b1;
        @(negedge tck);
        update_dr = 1'b0;
    endtask

    task automatic send_text();
        foreach (text_q[i]) begin
            scan_byte(text_q[i], 1'b1);
        end
        // Result lands four cycles after the last update
        repeat (SETTLE_CYCLES) @(negedge tck);
    endtask

    task automatic readout(input tap_pkg::result_t value, input logic [127:0] name);
        @(negedge tck);
        ir_is_user  = 1'b1;
        capture_dr  = 1'b1;
        check_start = 1'b1;
        exp_value   = value;
        test_name   = name;
        @(negedge tck);
        capture_dr  = 1'b0;
        check_start = 1'b0;
        shift_dr    = 1'b1;
        repeat (tap_pkg::RESULT_BITS) @(negedge tck);
        shift_dr = 1'b0;
    endtask

    always @(posedge tck) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        int v;
        tdi              = 1'b0;
        test_logic_reset = 1'b0;
        run_test_idle    = 1'b0;
        ir_is_user       = 1'b0;
        capture_dr       = 1'b0;
        shift_dr         = 1'b0;
        update_dr        = 1'b0;
        check_start      = 1'b0;
        exp_value        = '0;
        test_name        = '0;
        lfsr             = SEED;
        arst_n           = 1'b0;
        repeat (RESET_CYCLES) @(negedge tck);
        arst_n = 1'b1;
        fill_pool();

        readout(16'h0000, "after_reset");

        load_fixed();
        send_text();
        readout(model_result, "fixed_graph");

        for (int t = 0; t < NUM_RANDOM; t++) begin
            make_graph();
            send_text();
            readout(model_result, "random_graph");
        end

        // Non-user scans with random bytes between the real ones
        make_graph();
        foreach (text_q[i]) begin
            draw_bits(tap_pkg::BYTE_BITS, v);
            scan_byte(tap_pkg::byte_t'(v), 1'b0);
            scan_byte(text_q[i], 1'b1);
        end
        repeat (SETTLE_CYCLES) @(negedge tck);
        readout(model_result, "non_user_scans");

        // Held result of 1, then half a graph, then a TAP reset
        load_fixed();
        send_text();
        make_graph();
        for (int i = 0; i < text_q.size() / 2; i++) begin
            scan_byte(text_q[i], 1'b1);
        end
        @(negedge tck);
        test_logic_reset = 1'b1;
        @(negedge tck);
        test_logic_reset = 1'b0;
        readout(16'h0000, "reset_clears");
        make_graph();
        send_text();
        readout(model_result, "after_tap_reset");

        readout(model_result, "repeat_first");
        readout(model_result, "repeat_second");

        repeat (2) @(negedge tck);
        $display("Tests: %0d run, %0d passed, %0d failed",
                 checks_done, checks_done - errors, errors);
        if (errors == 0 && checks_done == NUM_READOUTS) begin
            $display("TB PASSED");
        end else begin
            if (checks_done != NUM_READOUTS) begin
                $display("Only %0d of %0d readouts completed", checks_done, NUM_READOUTS);
            end
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
